//--- source/stream_consts.svh
`ifndef STREAM_CONSTS_SVH
`define STREAM_CONSTS_SVH

// Datapath and setting widths
`define DATA_W      32
`define COUNT_W     16

// LANE_SEL_W must cover NUM_LANES
`define NUM_LANES   16
`define LANE_SEL_W  4

// Configuration map
`define CFG_ADDR_W          6
`define CFG_SRC_START       0
`define CFG_SRC_INCR        1
`define CFG_SRC_COUNT       2
`define CFG_SRC_DELAY       3
`define CFG_MERGE_SKIP      4
`define CFG_LANE_CONST_BASE 16  // Lane i constant at base + i
`define CFG_LANE_OP_BASE    32  // Lane i opcode at base + i

`endif

//--- source/stream_pkg.sv
package stream_pkg;

    // Codes 6 and 7 fall back to pass
    typedef enum logic [2:0] {
        OP_PASS = 3'd0,  // Operand through
        OP_ADD  = 3'd1,  // Operand + constant
        OP_SUB  = 3'd2,  // Operand - constant
        OP_MUL  = 3'd3,  // Low word of product
        OP_ACC  = 3'd4,  // Running sum of operands
        OP_MAX  = 3'd5   // Running unsigned max
    } lane_op_e;

    // Stream source FSM
    typedef enum logic [1:0] {
        SRC_IDLE = 2'd0,
        SRC_WAIT = 2'd1,  // Start delay
        SRC_EMIT = 2'd2   // One operand per cycle
    } src_state_e;

endpackage

//--- source/stream_config.sv
`include "stream_consts.svh"

module stream_config (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    cfg_we,
    input  logic [`CFG_ADDR_W-1:0]  cfg_addr,
    input  logic [`DATA_W-1:0]      cfg_data,

    output logic [`DATA_W-1:0]      src_start,
    output logic [`DATA_W-1:0]      src_incr,
    output logic [`COUNT_W-1:0]     src_count,
    output logic [`COUNT_W-1:0]     src_delay,
    output logic [`COUNT_W-1:0]     merge_skip,

    output logic [`DATA_W-1:0]      lane_const [`NUM_LANES],
    output stream_pkg::lane_op_e    lane_op [`NUM_LANES]
);

    logic [`CFG_ADDR_W-1:0] const_off;
    logic [`CFG_ADDR_W-1:0] op_off;
    logic                   const_hit;
    logic                   op_hit;

    // Offsets into the two lane windows
    assign const_off = cfg_addr - `CFG_ADDR_W'(`CFG_LANE_CONST_BASE);
    assign op_off    = cfg_addr - `CFG_ADDR_W'(`CFG_LANE_OP_BASE);

    assign const_hit = (cfg_addr >= `CFG_ADDR_W'(`CFG_LANE_CONST_BASE)) &&
                       (const_off < `CFG_ADDR_W'(`NUM_LANES));
    assign op_hit    = (cfg_addr >= `CFG_ADDR_W'(`CFG_LANE_OP_BASE)) &&
                       (op_off < `CFG_ADDR_W'(`NUM_LANES));

    // Source and merge settings
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            src_start  <= '0;
            src_incr   <= '0;
            src_count  <= '0;
            src_delay  <= '0;
            merge_skip <= '0;
        end else if (cfg_we) begin
            case (cfg_addr)
                `CFG_SRC_START:  src_start  <= cfg_data;
                `CFG_SRC_INCR:   src_incr   <= cfg_data;
                `CFG_SRC_COUNT:  src_count  <= cfg_data[`COUNT_W-1:0];
                `CFG_SRC_DELAY:  src_delay  <= cfg_data[`COUNT_W-1:0];
                `CFG_MERGE_SKIP: merge_skip <= cfg_data[`COUNT_W-1:0];
                default: ;  // Lane windows handled below
            endcase
        end
    end

    // Per-lane constants
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                lane_const[i] <= '0;
            end
        end else if (cfg_we && const_hit) begin
            lane_const[const_off[`LANE_SEL_W-1:0]] <= cfg_data;
        end
    end

    // Per-lane opcodes
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `NUM_LANES; i++) begin
                lane_op[i] <= stream_pkg::OP_PASS;
            end
        end else if (cfg_we && op_hit) begin
            lane_op[op_off[`LANE_SEL_W-1:0]] <= stream_pkg::lane_op_e'(cfg_data[2:0]);
        end
    end

endmodule

//--- source/stream_source.sv
`include "stream_consts.svh"

module stream_source (
    input  logic                clk,
    input  logic                rst,
    input  logic                run,

    input  logic [`DATA_W-1:0]  src_start,
    input  logic [`DATA_W-1:0]  src_incr,
    input  logic [`COUNT_W-1:0] src_count,
    input  logic [`COUNT_W-1:0] src_delay,

    output logic                op_valid,
    output logic [`DATA_W-1:0]  op_data,
    output logic                busy
);

    stream_pkg::src_state_e state;

    logic [`COUNT_W-1:0] delay_cnt;
    logic [`COUNT_W-1:0] items_left;
    logic [`DATA_W-1:0]  value;
    logic [`DATA_W-1:0]  incr;

    // Control FSM
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= stream_pkg::SRC_IDLE;
            delay_cnt  <= '0;
            items_left <= '0;
        end else begin
            case (state)
                stream_pkg::SRC_IDLE: begin
                    if (run) begin
                        state      <= stream_pkg::SRC_WAIT;
                        delay_cnt  <= src_delay;
                        items_left <= src_count;
                    end
                end
                stream_pkg::SRC_WAIT: begin
                    if (items_left == '0) begin
                        state <= stream_pkg::SRC_IDLE;  // Empty run
                    end else if (delay_cnt == '0) begin
                        state <= stream_pkg::SRC_EMIT;
                    end else begin
                        delay_cnt <= delay_cnt - 1'b1;
                    end
                end
                stream_pkg::SRC_EMIT: begin
                    items_left <= items_left - 1'b1;
                    if (items_left == `COUNT_W'(1)) begin
                        state <= stream_pkg::SRC_IDLE;  // Last item out
                    end
                end
                default: state <= stream_pkg::SRC_IDLE;
            endcase
        end
    end

    // Sequence value steps once per emitted item
    always_ff @(posedge clk) begin
        if (run && state == stream_pkg::SRC_IDLE) begin
            value <= src_start;
            incr  <= src_incr;
        end else if (state == stream_pkg::SRC_EMIT) begin
            value <= value + incr;
        end
    end

    assign op_valid = (state == stream_pkg::SRC_EMIT);
    assign op_data  = value;
    assign busy     = (state != stream_pkg::SRC_IDLE);

endmodule

//--- source/lane_alu.sv
`include "stream_consts.svh"

module lane_alu (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,

    input  logic                  op_valid,
    input  logic [`DATA_W-1:0]    op_data,
    input  logic [`DATA_W-1:0]    lane_const,
    input  stream_pkg::lane_op_e  lane_op,

    output logic                  res_valid,
    output logic [`DATA_W-1:0]    res_data
);

    logic [`DATA_W-1:0] acc;
    logic [`DATA_W-1:0] max_val;
    logic [`DATA_W-1:0] acc_next;
    logic [`DATA_W-1:0] max_next;
    logic [`DATA_W-1:0] result;

    // Running state including the current operand
    assign acc_next = acc + op_data;
    assign max_next = (op_data > max_val) ? op_data : max_val;

    always_comb begin
        case (lane_op)
            stream_pkg::OP_ADD: result = op_data + lane_const;
            stream_pkg::OP_SUB: result = op_data - lane_const;
            stream_pkg::OP_MUL: result = op_data * lane_const;  // Wraps to DATA_W
            stream_pkg::OP_ACC: result = acc_next;
            stream_pkg::OP_MAX: result = max_next;
            default:            result = op_data;
        endcase
    end

    // Strobe and running state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            res_valid <= 1'b0;
            acc       <= '0;
            max_val   <= '0;
        end else if (run) begin
            res_valid <= 1'b0;
            acc       <= '0;
            max_val   <= '0;
        end else begin
            res_valid <= op_valid;
            if (op_valid) begin
                acc     <= acc_next;
                max_val <= max_next;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid) begin
            res_data <= result;
        end
    end

endmodule

//--- source/stream_merge.sv
`include "stream_consts.svh"

module stream_merge (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  run,

    input  logic [`COUNT_W-1:0]   merge_skip,

    input  logic                  res_valid,
    input  logic [`DATA_W-1:0]    res_data [`NUM_LANES],

    output logic                  out_valid,
    output logic [`DATA_W-1:0]    out_data
);

    logic [`COUNT_W-1:0]    skip_cnt;
    logic [`LANE_SEL_W-1:0] counter;
    logic                   take;

    // A lane strobe past the skip window emits one word
    assign take = res_valid && (skip_cnt == '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            skip_cnt  <= '0;
            counter   <= '0;
            out_valid <= 1'b0;
        end else if (run) begin
            skip_cnt  <= merge_skip;
            counter   <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
            if (res_valid && skip_cnt != '0) begin
                skip_cnt <= skip_cnt - 1'b1;  // Drop leading result
            end
            if (take) begin
                counter <= counter + 1'b1;  // Wraps at NUM_LANES
            end
        end
    end

    // Round-robin select
    always_ff @(posedge clk) begin
        if (take && !run) begin
            out_data <= res_data[counter];
        end
    end

endmodule

//--- source/stream_top.sv
`include "stream_consts.svh"

module stream_top (
    input  logic                    clk,
    input  logic                    rst,

    input  logic                    cfg_we,
    input  logic [`CFG_ADDR_W-1:0]  cfg_addr,
    input  logic [`DATA_W-1:0]      cfg_data,
    input  logic                    run,

    output logic                    busy,
    output logic                    out_valid,
    output logic [`DATA_W-1:0]      out_data
);

    logic [`DATA_W-1:0]     src_start;
    logic [`DATA_W-1:0]     src_incr;
    logic [`COUNT_W-1:0]    src_count;
    logic [`COUNT_W-1:0]    src_delay;
    logic [`COUNT_W-1:0]    merge_skip;

    logic [`DATA_W-1:0]     lane_const [`NUM_LANES];
    stream_pkg::lane_op_e   lane_op [`NUM_LANES];

    logic                   op_valid;
    logic [`DATA_W-1:0]     op_data;

    logic [`NUM_LANES-1:0]  res_valid;
    logic [`DATA_W-1:0]     res_data [`NUM_LANES];

    stream_config u_config (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .src_start  (src_start),
        .src_incr   (src_incr),
        .src_count  (src_count),
        .src_delay  (src_delay),
        .merge_skip (merge_skip),
        .lane_const (lane_const),
        .lane_op    (lane_op)
    );

    stream_source u_source (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .src_start  (src_start),
        .src_incr   (src_incr),
        .src_count  (src_count),
        .src_delay  (src_delay),
        .op_valid   (op_valid),
        .op_data    (op_data),
        .busy       (busy)
    );

    // Same operand broadcast to every lane
    for (genvar i = 0; i < `NUM_LANES; i++) begin : g_lane
        lane_alu u_lane (
            .clk        (clk),
            .rst        (rst),
            .run        (run),
            .op_valid   (op_valid),
            .op_data    (op_data),
            .lane_const (lane_const[i]),
            .lane_op    (lane_op[i]),
            .res_valid  (res_valid[i]),
            .res_data   (res_data[i])
        );
    end

    stream_merge u_merge (
        .clk        (clk),
        .rst        (rst),
        .run        (run),
        .merge_skip (merge_skip),
        .res_valid  (res_valid[0]),  // Lanes run in lockstep
        .res_data   (res_data),
        .out_valid  (out_valid),
        .out_data   (out_data)
    );

endmodule

//--- bench/tb_clock.sv
module tb_clock (
    output logic clk
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;  // 10 ns period
    end

endmodule

//--- bench/stream_tb.sv
`include "stream_consts.svh"

module stream_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_RUNS        = 20;
    localparam int MAX_COUNT       = 60;
    localparam int MAX_DELAY       = 10;
    localparam int MAX_SKIP        = 20;
    localparam int RUN_OVERHEAD    = 2 * `NUM_LANES + 20;  // Config writes and drain
    localparam int CLK_PERIOD      = 10;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * (MAX_COUNT + MAX_DELAY + RUN_OVERHEAD) + 20;

    logic                   clk;
    logic                   rst;
    logic                   cfg_we;
    logic [`CFG_ADDR_W-1:0] cfg_addr;
    logic [`DATA_W-1:0]     cfg_data;
    logic                   run;
    logic                   busy;
    logic                   out_valid;
    logic [`DATA_W-1:0]     out_data;

    integer seed = 23;

    // Current run configuration
    logic [`DATA_W-1:0]   cfg_start;
    logic [`DATA_W-1:0]   cfg_incr;
    logic [`COUNT_W-1:0]  cfg_count;
    logic [`COUNT_W-1:0]  cfg_delay;
    logic [`COUNT_W-1:0]  cfg_skip;
    logic [`DATA_W-1:0]   cfg_const [`NUM_LANES];
    stream_pkg::lane_op_e cfg_op [`NUM_LANES];

    logic [`DATA_W-1:0]  expected [$];
    logic [`COUNT_W-1:0] exp_words;
    logic [`COUNT_W-1:0] received;

    tb_clock u_clock (
        .clk (clk)
    );

    stream_top u_stream_top (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_data  (cfg_data),
        .run       (run),
        .busy      (busy),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    task automatic report_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic check_data(input logic [`DATA_W-1:0] actual,
                              input logic [`DATA_W-1:0] want, input string what);
        if (actual !== want) begin
            $display("error at %0d ns: %s is %h, expected %h", $time, what, actual, want);
            report_failure();
        end
    endtask

    task automatic check_count(input logic [`COUNT_W-1:0] actual,
                               input logic [`COUNT_W-1:0] want, input string what);
        if (actual !== want) begin
            $display("error at %0d ns: %s is %0d, expected %0d", $time, what, actual, want);
            report_failure();
        end
    endtask

    task automatic check_busy(input logic actual, input logic want, input string what);
        if (actual !== want) begin
            $display("error at %0d ns: %s is %b, expected %b", $time, what, actual, want);
            report_failure();
        end
    endtask

    function automatic int rand_range(input int lo, input int hi);
        int unsigned r;
        r = $random(seed);
        return lo + int'(r % (hi - lo + 1));
    endfunction

    function automatic logic [`DATA_W-1:0] rand_word();
        return $random(seed);
    endfunction

    task automatic write_cfg(input int addr, input logic [`DATA_W-1:0] data);
        cfg_we   = 1'b1;
        cfg_addr = `CFG_ADDR_W'(addr);
        cfg_data = data;
        @(negedge clk);
        cfg_we   = 1'b0;
    endtask

    task automatic pick_config(input int idx);
        cfg_start = rand_word();
        cfg_incr  = rand_word();
        cfg_count = `COUNT_W'(rand_range(0, MAX_COUNT));
        cfg_delay = `COUNT_W'(rand_range(0, MAX_DELAY));
        cfg_skip  = `COUNT_W'(rand_range(0, MAX_SKIP));
        for (int i = 0; i < `NUM_LANES; i++) begin
            cfg_const[i] = rand_word();
            cfg_op[i]    = stream_pkg::lane_op_e'(3'(rand_range(0, 5)));
        end
        case (idx)
            0: begin  // Plain sequence in round-robin order
                cfg_count = `COUNT_W'(rand_range(`NUM_LANES, MAX_COUNT));
                cfg_skip  = '0;
                for (int i = 0; i < `NUM_LANES; i++) begin
                    cfg_op[i] = stream_pkg::OP_PASS;
                end
            end
            1: begin  // Running state replayed unchanged by the next run
                cfg_count = `COUNT_W'(rand_range(`NUM_LANES, MAX_COUNT));
                for (int i = 0; i < `NUM_LANES; i++) begin
                    cfg_op[i] = (i % 2 == 0) ? stream_pkg::OP_ACC : stream_pkg::OP_MAX;
                end
            end
            3: cfg_count = '0;
            4: begin  // Everything skipped
                cfg_skip  = `COUNT_W'(rand_range(1, MAX_SKIP));
                cfg_count = `COUNT_W'(rand_range(0, int'(cfg_skip)));
            end
            default: ;
        endcase
    endtask

    task automatic write_config();
        write_cfg(`CFG_SRC_START, cfg_start);
        write_cfg(`CFG_SRC_INCR, cfg_incr);
        write_cfg(`CFG_SRC_COUNT, `DATA_W'(cfg_count));
        write_cfg(`CFG_SRC_DELAY, `DATA_W'(cfg_delay));
        write_cfg(`CFG_MERGE_SKIP, `DATA_W'(cfg_skip));
        for (int i = 0; i < `NUM_LANES; i++) begin
            write_cfg(`CFG_LANE_CONST_BASE + i, cfg_const[i]);
            write_cfg(`CFG_LANE_OP_BASE + i, `DATA_W'(cfg_op[i]));
        end
    endtask

    // Reference model of the lanes and the merge order
    task automatic build_expected();
        logic [`DATA_W-1:0] acc [`NUM_LANES];
        logic [`DATA_W-1:0] mx [`NUM_LANES];
        logic [`DATA_W-1:0] operand;
        logic [`DATA_W-1:0] res;
        int                 n;
        expected.delete();
        for (int i = 0; i < `NUM_LANES; i++) begin
            acc[i] = '0;
            mx[i]  = '0;
        end
        for (int j = 0; j < int'(cfg_count); j++) begin
            operand = cfg_start + cfg_incr * `DATA_W'(j);
            n = j - int'(cfg_skip);
            for (int i = 0; i < `NUM_LANES; i++) begin
                acc[i] = acc[i] + operand;
                if (operand > mx[i]) begin
                    mx[i] = operand;
                end
                case (cfg_op[i])
                    stream_pkg::OP_ADD: res = operand + cfg_const[i];
                    stream_pkg::OP_SUB: res = operand - cfg_const[i];
                    stream_pkg::OP_MUL: res = operand * cfg_const[i];
                    stream_pkg::OP_ACC: res = acc[i];
                    stream_pkg::OP_MAX: res = mx[i];
                    default:            res = operand;
                endcase
                if (n >= 0 && n % `NUM_LANES == i) begin
                    expected.push_back(res);
                end
            end
        end
        exp_words = `COUNT_W'(expected.size());
    endtask

    task automatic do_run();
        build_expected();
        received = '0;
        run = 1'b1;
        @(negedge clk);
        run = 1'b0;
        check_busy(busy, 1'b1, "busy after run");
        while (busy) begin
            @(negedge clk);
        end
        repeat (3) @(negedge clk);  // Lane and merge stages drain
        check_count(received, exp_words, "words received");
    endtask

    // Output monitor
    always @(negedge clk) begin
        if (!rst && out_valid) begin
            if (expected.size() == 0) begin
                $display("an output word %h arrived at %0d ns when none was expected",
                         out_data, $time);
                report_failure();
            end else begin
                check_data(out_data, expected.pop_front(), "out_data");
                received = received + 1'b1;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("the run hung, watchdog expired at %0d ns", $time);
        report_failure();
    end

    initial begin
        rst      = 1'b1;
        cfg_we   = 1'b0;
        cfg_addr = '0;
        cfg_data = '0;
        run      = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        check_busy(busy, 1'b0, "busy after reset");
        repeat (3) @(negedge clk);  // Monitor flags any stray out_valid
        for (int r = 0; r < NUM_RUNS; r++) begin
            if (r != 2) begin  // Run 2 repeats the settings of run 1
                pick_config(r);
                write_config();
            end
            do_run();
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- sim.f
+incdir+source
source/stream_pkg.sv
source/stream_config.sv
source/stream_source.sv
source/lane_alu.sv
source/stream_merge.sv
source/stream_top.sv
bench/tb_clock.sv
bench/stream_tb.sv
